//--- cl_rle.f
+incdir+.
cl_rle_pkg.sv
cl_run_tracker.sv
cl_sym_emitter.sv
cl_table_stats.sv
cl_rle_top.sv
cl_rle_assertions.sv
cl_rle_tb.sv

//--- cl_rle_assertions.sv
////////////////////////////////////////
// bound into cl_rle_top and sampled on clk_gated
// fail_count holds the number of failed checks
////////////////////////////////////////
`include "cl_rle_consts.svh"
`default_nettype none

module cl_rle_assertions (
  input wire logic                     clk_gated,
  input wire logic                     rst_n,
  input wire logic                     sym_valid,
  input wire cl_rle_pkg::rle_sym_out_t sym,
  input wire logic                     sym_last,
  input wire logic                     done
);
  timeunit 1ns;
  timeprecision 1ps;

  import cl_rle_pkg::*;

  int         fail_count = 0;
  extra_len_t want_xlen;

  // run symbols carry a fixed number of extra bits and literals none
  always_comb
  begin
    case (sym.sym)
      rle_sym_t'(`CL_SYM_REPEAT):     want_xlen = extra_len_t'(`CL_XLEN_REPEAT);
      rle_sym_t'(`CL_SYM_ZERO_SHORT): want_xlen = extra_len_t'(`CL_XLEN_ZERO_SHORT);
      rle_sym_t'(`CL_SYM_ZERO_LONG):  want_xlen = extra_len_t'(`CL_XLEN_ZERO_LONG);
      default:                        want_xlen = '0;
    endcase
  end

  a_no_overlap : assert property (@(posedge clk_gated) disable iff (!rst_n)
    !(sym_valid && done))
    else
    begin
      fail_count++;
      $error("sym_valid and done are high in the same cycle");
    end

  a_extra_len : assert property (@(posedge clk_gated) disable iff (!rst_n)
    sym_valid |-> sym.extra_len == want_xlen)
    else
    begin
      fail_count++;
      $error("extra length %0d does not fit symbol %0d", sym.extra_len, sym.sym);
    end

  a_sym_range : assert property (@(posedge clk_gated) disable iff (!rst_n)
    sym_valid |-> sym.sym <= rle_sym_t'(`CL_SYM_ZERO_LONG))
    else
    begin
      fail_count++;
      $error("symbol %0d is outside the code-length alphabet", sym.sym);
    end

  a_done_after_last : assert property (@(posedge clk_gated) disable iff (!rst_n)
    done |-> $past(sym_valid && sym_last))
    else
    begin
      fail_count++;
      $error("done without sym_last in the cycle before");
    end

endmodule

bind cl_rle_top cl_rle_assertions u_cl_rle_assertions (
  .clk_gated (clk_gated),
  .rst_n     (rst_n),
  .sym_valid (sym_valid),
  .sym       (sym),
  .sym_last  (sym_last),
  .done      (done)
);

`default_nettype wire

//--- cl_rle_consts.svh
////////////////////////////////////////
// deflate code-length alphabet constants, fixed by RFC 1951
// widths here size every type in cl_rle_pkg
////////////////////////////////////////
`ifndef CL_RLE_CONSTS_SVH
`define CL_RLE_CONSTS_SVH

// run-length symbols of the code-length alphabet
`define CL_SYM_REPEAT      16
`define CL_SYM_ZERO_SHORT  17
`define CL_SYM_ZERO_LONG   18

`define CL_REPEAT_MIN      3
`define CL_REPEAT_MAX      6
`define CL_ZERO_SHORT_MIN  3
`define CL_ZERO_SHORT_MAX  10
`define CL_ZERO_LONG_MIN   11
`define CL_ZERO_LONG_MAX   138

`define CL_MAX_ENTRIES     288

// extra bits carried by each run symbol
`define CL_XLEN_REPEAT     2
`define CL_XLEN_ZERO_SHORT 3
`define CL_XLEN_ZERO_LONG  7

`define CL_CODE_LEN_W      4
`define CL_SYM_W           5
`define CL_EXTRA_VAL_W     7
`define CL_EXTRA_LEN_W     3
`define CL_ZERO_CNT_W      8
`define CL_REP_CNT_W       3
`define CL_EXTRA_TOTAL_W   11

`endif

//--- cl_rle_pkg.sv
////////////////////////////////////////
// shared types for the code-length run encoder
////////////////////////////////////////
`include "cl_rle_consts.svh"
`default_nettype none

package cl_rle_pkg;

  typedef logic [`CL_CODE_LEN_W-1:0]    code_len_t;
  typedef logic [`CL_SYM_W-1:0]         rle_sym_t;
  typedef logic [`CL_EXTRA_VAL_W-1:0]   extra_val_t;
  typedef logic [`CL_EXTRA_LEN_W-1:0]   extra_len_t;
  typedef logic [`CL_ZERO_CNT_W-1:0]    zero_cnt_t;
  typedef logic [`CL_REP_CNT_W-1:0]     rep_cnt_t;
  typedef logic [$clog2(`CL_MAX_ENTRIES + 1)-1:0] sym_count_t;
  typedef logic [`CL_EXTRA_TOTAL_W-1:0] extra_total_t;

  // one tracker decision, emitted in field order zero, repeat, literal
  typedef struct packed {
    zero_cnt_t zero_run;
    rep_cnt_t  rep_cnt;
    code_len_t rep_val;
    logic      lit_valid;
    code_len_t lit_val;
    logic      table_end;
  } flush_req_t;

  typedef struct packed {
    rle_sym_t   sym;
    extra_val_t extra;
    extra_len_t extra_len;
  } rle_sym_out_t;

  typedef struct packed {
    sym_count_t   sym_count;
    extra_total_t extra_total;
  } table_summary_t;

  typedef enum logic {
    idle,
    in_table
  } tracker_state_t;

endpackage

`default_nettype wire

//--- cl_rle_tb.sv
////////////////////////////////////////
// directed tests against a software model of the deflate run rules
// inputs are strobed every 4 cycles and tables hold at most 288 entries
////////////////////////////////////////
`default_nettype none

module cl_rle_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import cl_rle_pkg::*;

  localparam int SYM_TIMEOUT  = 2000;  // a 137-zero gap takes about 550 cycles
  localparam int DONE_TIMEOUT = 8;

  logic           clk_gated;
  logic           rst_n;
  logic           cl_valid;
  code_len_t      cl_len;
  logic           cl_last;
  logic           sym_valid;
  rle_sym_out_t   sym;
  logic           sym_last;
  logic           done;
  table_summary_t summary;

  code_len_t      cur_tbl[$];
  code_len_t      stim_len[$];
  logic           stim_last[$];
  rle_sym_out_t   exp_sym[$];
  logic           exp_last[$];
  table_summary_t exp_sum[$];
  int             mdl_count;
  int             mdl_extra;
  logic [31:0]    rng_state;

  cl_rle_top u_cl_rle_top (.*);

  initial
  begin
    clk_gated = 1'b0;
    forever #10 clk_gated = ~clk_gated;
  end

  task automatic stop_with_error(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_sym(rle_sym_out_t got, rle_sym_out_t want);
    if (got !== want)
      stop_with_error($sformatf("mismatch at %0t: sym got %0d/%0d/%0d expected %0d/%0d/%0d",
        $time, got.sym, got.extra, got.extra_len, want.sym, want.extra, want.extra_len));
  endtask

  task automatic check_flag(string name, logic got, logic want);
    if (got !== want)
      stop_with_error($sformatf("mismatch at %0t: %s got %b expected %b",
        $time, name, got, want));
  endtask

  task automatic check_last(logic got, logic want);
    check_flag("sym_last", got, want);
  endtask

  task automatic check_summary(table_summary_t got, table_summary_t want);
    if (got !== want)
      stop_with_error($sformatf("mismatch at %0t: summary got %0d/%0d expected %0d/%0d",
        $time, got.sym_count, got.extra_total, want.sym_count, want.extra_total));
  endtask

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic code_len_t random_len();
    rng_state = xorshift(rng_state);
    if (rng_state[0])
      return code_len_t'(0);  // half of all entries are zeros
    else
      return code_len_t'(rng_state[11:4] % 15 + 1);
  endfunction

  task automatic push_sym(int s, int x, int l);
    rle_sym_out_t e;
    e.sym       = rle_sym_t'(s);
    e.extra     = extra_val_t'(x);
    e.extra_len = extra_len_t'(l);
    exp_sym.push_back(e);
    exp_last.push_back(1'b0);
    mdl_count++;
    mdl_extra += l;
  endtask

  task automatic close_zeros(inout int n);
    if (n >= 11)
      push_sym(18, n - 11, 7);
    else if (n >= 3)
      push_sym(17, n - 3, 3);
    else
      repeat (n) push_sym(0, 0, 0);
    n = 0;
  endtask

  task automatic close_repeat(inout int r, input int v);
    if (r >= 3)
      push_sym(16, r - 3, 2);
    else
      repeat (r) push_sym(v, 0, 0);
    r = 0;
  endtask

  // turns cur_tbl into stimulus plus the expected symbols and summary
  task automatic queue_table();
    int             zeros;
    int             rep;
    int             prev;
    int             len;
    table_summary_t s;
    zeros     = 0;
    rep       = 0;
    prev      = 0;
    mdl_count = 0;
    mdl_extra = 0;
    foreach (cur_tbl[i])
    begin
      len = cur_tbl[i];
      stim_len.push_back(cur_tbl[i]);
      stim_last.push_back(i == cur_tbl.size() - 1);
      if (len == 0)
      begin
        close_repeat(rep, prev);
        prev = 0;
        zeros++;
        if (zeros == 138)
          close_zeros(zeros);  // the full run goes out as 18 with extra 127
      end
      else
      begin
        close_zeros(zeros);
        if (len == prev)
        begin
          rep++;
          if (rep == 6)
            close_repeat(rep, prev);
        end
        else
        begin
          close_repeat(rep, prev);
          push_sym(len, 0, 0);
          prev = len;
        end
      end
    end
    close_zeros(zeros);
    close_repeat(rep, prev);
    exp_last[exp_last.size() - 1] = 1'b1;
    s.sym_count   = sym_count_t'(mdl_count);
    s.extra_total = extra_total_t'(mdl_extra);
    exp_sum.push_back(s);
    cur_tbl.delete();
  endtask

  task automatic drive_stream();
    while (stim_len.size() > 0)
    begin
      @(posedge clk_gated);
      cl_valid <= 1'b1;
      cl_len   <= stim_len.pop_front();
      cl_last  <= stim_last.pop_front();
      @(posedge clk_gated);
      cl_valid <= 1'b0;
      cl_last  <= 1'b0;
      repeat (2) @(posedge clk_gated);
    end
  endtask

  task automatic wait_for_sym();
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk_gated);
      cycles++;
    end
    while (!sym_valid && cycles < SYM_TIMEOUT);
    if (!sym_valid)
      stop_with_error($sformatf("no symbol arrived within %0d cycles", SYM_TIMEOUT));
  endtask

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk_gated);
      cycles++;
    end
    while (!done && cycles < DONE_TIMEOUT);
    if (!done)
      stop_with_error("done did not follow the last symbol of a table");
  endtask

  task automatic check_stream();
    rle_sym_out_t want;
    logic         want_last;
    while (exp_sym.size() > 0)
    begin
      wait_for_sym();
      want      = exp_sym.pop_front();
      want_last = exp_last.pop_front();
      check_sym(sym, want);
      check_last(sym_last, want_last);
      if (want_last)
      begin
        wait_for_done();
        check_summary(summary, exp_sum.pop_front());
      end
    end
  endtask

  task automatic run_stream();
    fork
      drive_stream();
      check_stream();
    join
  endtask

  task automatic test_reset_idle();
    repeat (20)
    begin
      @(negedge clk_gated);
      check_flag("sym_valid", sym_valid, 1'b0);
      check_flag("sym_last", sym_last, 1'b0);
      check_flag("done", done, 1'b0);
    end
  endtask

  task automatic test_literals();
    for (int i = 0; i < 19; i++)
      cur_tbl.push_back(code_len_t'((i * 7) % 15 + 1));
    queue_table();
    run_stream();
  endtask

  task automatic test_zero_runs();
    int runs[8] = '{1, 2, 3, 10, 11, 138, 139, 200};
    foreach (runs[i])
    begin
      cur_tbl.push_back(code_len_t'(4 + i % 2));
      repeat (runs[i]) cur_tbl.push_back(code_len_t'(0));
      if (i >= 5)
      begin
        cur_tbl.push_back(code_len_t'(9));  // split so no table exceeds 288 entries
        queue_table();
      end
    end
    cur_tbl.push_back(code_len_t'(5));
    cur_tbl.push_back(code_len_t'(0));
    queue_table();
    run_stream();
  endtask

  task automatic test_repeats();
    int vals[8] = '{7, 3, 7, 3, 7, 6, 0, 6};
    int lens[8] = '{2, 3, 4, 7, 13, 4, 1, 3};
    foreach (vals[i])
      repeat (lens[i]) cur_tbl.push_back(code_len_t'(vals[i]));
    queue_table();
    run_stream();
  endtask

  task automatic test_random_tables();
    int sizes[3] = '{19, 30, 288};
    foreach (sizes[t])
    begin
      repeat (sizes[t]) cur_tbl.push_back(random_len());
      queue_table();
    end
    run_stream();
  endtask

  always @(negedge clk_gated)
  begin
    if (u_cl_rle_top.u_cl_rle_assertions.fail_count != 0)
      stop_with_error("a bound assertion on the DUT outputs failed");
  end

  initial
  begin
    rst_n     = 1'b0;
    cl_valid  = 1'b0;
    cl_len    = '0;
    cl_last   = 1'b0;
    rng_state = 32'd6;
    repeat (10) @(posedge clk_gated);
    rst_n <= 1'b1;
    test_reset_idle();
    test_literals();
    test_zero_runs();
    test_repeats();
    test_random_tables();
    repeat (4) @(posedge clk_gated);
    if (u_cl_rle_top.u_cl_rle_assertions.fail_count == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
      stop_with_error("a bound assertion on the DUT outputs failed");
  end

endmodule

`default_nettype wire

//--- cl_rle_top.sv
////////////////////////////////////////
// no back-pressure, strobes 4 or more cycles apart
////////////////////////////////////////
`default_nettype none

module cl_rle_top (
  input  wire logic                  clk_gated,
  input  wire logic                  rst_n,
  input  wire logic                  cl_valid,
  input  wire cl_rle_pkg::code_len_t cl_len,
  input  wire logic                  cl_last,
  output logic                       sym_valid,
  output cl_rle_pkg::rle_sym_out_t   sym,
  output logic                       sym_last,
  output logic                       done,
  output cl_rle_pkg::table_summary_t summary
);

  import cl_rle_pkg::*;

  logic       flush_valid;
  flush_req_t flush_req;

  cl_run_tracker u_run_tracker (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .cl_valid    (cl_valid),
    .cl_len      (cl_len),
    .cl_last     (cl_last),
    .flush_valid (flush_valid),
    .flush_req   (flush_req)
  );

  cl_sym_emitter u_sym_emitter (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .flush_valid (flush_valid),
    .flush_req   (flush_req),
    .sym_valid   (sym_valid),
    .sym         (sym),
    .sym_last    (sym_last)
  );

  cl_table_stats u_table_stats (
    .clk_gated (clk_gated),
    .rst_n     (rst_n),
    .sym_valid (sym_valid),
    .sym       (sym),
    .sym_last  (sym_last),
    .done      (done),
    .summary   (summary)
  );

endmodule

`default_nettype wire

//--- cl_run_tracker.sv
////////////////////////////////////////
// one flush request per input one cycle after its strobe
// inputs must be at least 4 cycles apart
////////////////////////////////////////
`include "cl_rle_consts.svh"
`default_nettype none

module cl_run_tracker (
  input  wire logic                   clk_gated,
  input  wire logic                   rst_n,
  input  wire logic                   cl_valid,
  input  wire cl_rle_pkg::code_len_t  cl_len,
  input  wire logic                   cl_last,
  output logic                        flush_valid,
  output cl_rle_pkg::flush_req_t      flush_req
);

  import cl_rle_pkg::*;

  tracker_state_t state;
  tracker_state_t state_nxt;
  zero_cnt_t      zero_cnt;
  zero_cnt_t      zero_nxt;
  zero_cnt_t      zero_inc;
  rep_cnt_t       rep_cnt;
  rep_cnt_t       rep_nxt;
  rep_cnt_t       rep_inc;
  code_len_t      prev_len;
  code_len_t      prev_nxt;
  code_len_t      cur_prev;
  flush_req_t     req_c;

  always_comb
  begin
    // a new table forgets the previous length
    cur_prev = (state == idle) ? '0 : prev_len;
    zero_inc = zero_cnt_t'(zero_cnt + 1'b1);
    rep_inc  = rep_cnt_t'(rep_cnt + 1'b1);

    state_nxt = cl_last ? idle : in_table;
    zero_nxt  = zero_cnt;
    rep_nxt   = rep_cnt;
    prev_nxt  = cur_prev;
    req_c     = '0;
    req_c.table_end = cl_last;

    if (cl_len == '0)
    begin
      // any zero closes an open repeat run and forgets the previous length
      req_c.rep_cnt = rep_cnt;
      req_c.rep_val = cur_prev;
      rep_nxt       = '0;
      prev_nxt      = '0;
      if (zero_inc == `CL_ZERO_LONG_MAX)
      begin
        req_c.zero_run = zero_inc;
        zero_nxt       = '0;
      end
      else if (cl_last)
      begin
        // a lone trailing zero goes out as a literal so it follows the repeats
        if (zero_inc == 1)
        begin
          req_c.lit_valid = 1'b1;
          req_c.lit_val   = '0;
        end
        else
          req_c.zero_run = zero_inc;
        zero_nxt = '0;
      end
      else
        zero_nxt = zero_inc;
    end
    else
    begin
      req_c.zero_run = zero_cnt;             // nonzero length closes the zero run
      zero_nxt       = '0;
      if (cl_len == cur_prev)
      begin
        if (rep_inc == `CL_REPEAT_MAX || cl_last)
        begin
          req_c.rep_cnt = rep_inc;
          req_c.rep_val = cur_prev;
          rep_nxt       = '0;
        end
        else
          rep_nxt = rep_inc;
      end
      else
      begin
        req_c.rep_cnt   = rep_cnt;
        req_c.rep_val   = cur_prev;
        req_c.lit_valid = 1'b1;
        req_c.lit_val   = cl_len;
        prev_nxt        = cl_len;
        rep_nxt         = '0;
      end
    end
  end

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= idle;
      zero_cnt    <= '0;
      rep_cnt     <= '0;
      prev_len    <= '0;
      flush_valid <= 1'b0;
    end
    else
    begin
      flush_valid <= cl_valid;
      if (cl_valid)
      begin
        state    <= state_nxt;
        zero_cnt <= zero_nxt;
        rep_cnt  <= rep_nxt;
        prev_len <= prev_nxt;
      end
    end
  end

  always_ff @(posedge clk_gated)
  begin
    if (cl_valid)
      flush_req <= req_c;
  end

endmodule

`default_nettype wire

//--- cl_sym_emitter.sv
////////////////////////////////////////
// up to 3 symbols per request, one per cycle
// a new request must not arrive while one is pending
////////////////////////////////////////
`include "cl_rle_consts.svh"
`default_nettype none

module cl_sym_emitter (
  input  wire logic                   clk_gated,
  input  wire logic                   rst_n,
  input  wire logic                   flush_valid,
  input  wire cl_rle_pkg::flush_req_t flush_req,
  output logic                        sym_valid,
  output cl_rle_pkg::rle_sym_out_t    sym,
  output logic                        sym_last
);

  import cl_rle_pkg::*;

  zero_cnt_t zero_left;
  zero_cnt_t zero_nxt;
  rep_cnt_t  rep_left;
  rep_cnt_t  rep_nxt;
  code_len_t rep_val;
  logic      lit_pend;
  logic      lit_nxt;
  code_len_t lit_val;
  logic      tbl_end;
  logic      remain;

  always_comb
  begin
    sym      = '0;                           // also the filler literal 0 of an empty table end
    zero_nxt = zero_left;
    rep_nxt  = rep_left;
    lit_nxt  = lit_pend;

    if (zero_left != '0)
    begin
      if (zero_left > `CL_ZERO_SHORT_MAX)
      begin
        sym.sym       = rle_sym_t'(`CL_SYM_ZERO_LONG);
        sym.extra     = extra_val_t'(zero_left - `CL_ZERO_LONG_MIN);
        sym.extra_len = extra_len_t'(`CL_XLEN_ZERO_LONG);
        zero_nxt      = '0;
      end
      else if (zero_left >= `CL_ZERO_SHORT_MIN)
      begin
        sym.sym       = rle_sym_t'(`CL_SYM_ZERO_SHORT);
        sym.extra     = extra_val_t'(zero_left - `CL_ZERO_SHORT_MIN);
        sym.extra_len = extra_len_t'(`CL_XLEN_ZERO_SHORT);
        zero_nxt      = '0;
      end
      else
        zero_nxt = zero_cnt_t'(zero_left - 1'b1);  // short runs go out as literal zeros
    end
    else if (rep_left != '0)
    begin
      if (rep_left >= `CL_REPEAT_MIN)
      begin
        sym.sym       = rle_sym_t'(`CL_SYM_REPEAT);
        sym.extra     = extra_val_t'(rep_left - `CL_REPEAT_MIN);
        sym.extra_len = extra_len_t'(`CL_XLEN_REPEAT);
        rep_nxt       = '0;
      end
      else
      begin
        sym.sym = {1'b0, rep_val};
        rep_nxt = rep_cnt_t'(rep_left - 1'b1);
      end
    end
    else if (lit_pend)
    begin
      sym.sym = {1'b0, lit_val};
      lit_nxt = 1'b0;
    end

    remain    = (zero_nxt != '0) || (rep_nxt != '0) || lit_nxt;
    sym_valid = (zero_left != '0) || (rep_left != '0) || lit_pend || tbl_end;
    sym_last  = tbl_end && !remain;
  end

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      zero_left <= '0;
      rep_left  <= '0;
      lit_pend  <= 1'b0;
      tbl_end   <= 1'b0;
    end
    else if (flush_valid)
    begin
      zero_left <= flush_req.zero_run;
      rep_left  <= flush_req.rep_cnt;
      lit_pend  <= flush_req.lit_valid;
      tbl_end   <= flush_req.table_end;
    end
    else if (sym_valid)
    begin
      zero_left <= zero_nxt;
      rep_left  <= rep_nxt;
      lit_pend  <= lit_nxt;
      tbl_end   <= tbl_end && remain;    // held until the last symbol leaves
    end
  end

  always_ff @(posedge clk_gated)
  begin
    if (flush_valid)
    begin
      rep_val <= flush_req.rep_val;
      lit_val <= flush_req.lit_val;
    end
  end

endmodule

`default_nettype wire

//--- cl_table_stats.sv
////////////////////////////////////////
// summary is valid only while done is high
////////////////////////////////////////
`default_nettype none

module cl_table_stats (
  input  wire logic                    clk_gated,
  input  wire logic                    rst_n,
  input  wire logic                    sym_valid,
  input  wire cl_rle_pkg::rle_sym_out_t sym,
  input  wire logic                    sym_last,
  output logic                         done,
  output cl_rle_pkg::table_summary_t   summary
);

  import cl_rle_pkg::*;

  sym_count_t   count_acc;
  sym_count_t   count_nxt;
  extra_total_t extra_acc;
  extra_total_t extra_nxt;

  // totals including the symbol on the bus this cycle
  assign count_nxt = sym_count_t'(count_acc + 1'b1);
  assign extra_nxt = extra_total_t'(extra_acc + sym.extra_len);

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count_acc <= '0;
      extra_acc <= '0;
      done      <= 1'b0;
    end
    else
    begin
      done <= sym_valid && sym_last;
      if (sym_valid)
      begin
        count_acc <= sym_last ? '0 : count_nxt;   // start clean for the next table
        extra_acc <= sym_last ? '0 : extra_nxt;
      end
    end
  end

  always_ff @(posedge clk_gated)
  begin
    if (sym_valid && sym_last)
    begin
      summary.sym_count   <= count_nxt;
      summary.extra_total <= extra_nxt;
    end
  end

endmodule

`default_nettype wire
